// File: Bender.yml
package:
  name: cpu_control

sources:
  - design/cpuControlPkg.sv
  - design/ctrlIf.sv
  - design/opcodeClassifier.sv
  - design/branchCondition.sv
  - design/controlTable.sv
  - design/cpuControl.sv
  - target: test
    files:
      - tb/controlChecker.sv
      - tb/cpuControlTb.sv

// File: design/branchCondition.sv
// Branch condition evaluation against the NZCV flags
`timescale 1ns/10ps

module branchCondition (
	input cpuControlPkg::condE cond,
	input cpuControlPkg::flagsT flags,
	output logic taken
);
	import cpuControlPkg::*;

	// Signed compare helper, true when N and V agree
	logic signedGe;

	assign signedGe = (flags.n == flags.v);

	always_comb begin
		case (cond)
			COND_EQ: taken = flags.z;
			COND_NE: taken = !flags.z;
			COND_CS: taken = flags.c;
			COND_CC: taken = !flags.c;
			COND_MI: taken = flags.n;
			COND_PL: taken = !flags.n;
			COND_VS: taken = flags.v;
			COND_VC: taken = !flags.v;
			// Unsigned compares
			COND_HI: taken = flags.c && !flags.z;
			COND_LS: taken = !flags.c || flags.z;
			// Signed compares
			COND_GE: taken = signedGe;
			COND_LT: taken = !signedGe;
			COND_GT: taken = !flags.z && signedGe;
			COND_LE: taken = flags.z || !signedGe;
			COND_AL: taken = 1'b1;
			// Reserved code 15
			default: taken = 1'b0;
		endcase
	end

endmodule

// File: design/controlTable.sv
// Control table mapping an instruction kind to the datapath control bundle
`timescale 1ns/10ps

module controlTable (
	input cpuControlPkg::instrKindE kind,
	input cpuControlPkg::instrT instr,
	input cpuControlPkg::flagsT flags,
	ctrlIf.driver ctrl
);
	import cpuControlPkg::*;

	condE cond;
	logic taken;

	assign cond = condE'(instr[COND_MSB:COND_LSB]);

	branchCondition branchCondition_i (
		.cond(cond),
		.flags(flags),
		.taken(taken)
	);

	always_comb begin
		// Unused fields stay at zero, PC falls through by default
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.shiftDir = SHIFT_LSL;
		ctrl.flagUpdate = 4'b0000;
		ctrl.reg1Loc = 2'd0;
		ctrl.reg2Loc = 2'd0;
		ctrl.reg3Loc = 2'd0;
		ctrl.opBSel = OPB_REG;
		ctrl.aluOp = ALU_ADD;
		ctrl.pcSel = PC_NEXT;
		ctrl.branch = 1'b0;
		ctrl.branchExchange = 1'b0;
		ctrl.wrDataSel = WR_SHIFT;
		ctrl.illegal = 1'b0;

		case (kind)
			KIND_MOVS: begin
				ctrl.regWrite = 1'b1;
				ctrl.flagUpdate = 4'b1100;
				ctrl.reg3Loc = 2'd2;
				ctrl.wrDataSel = WR_IMM;
			end
			KIND_MOV: begin
				ctrl.regWrite = 1'b1;
				ctrl.reg2Loc = 2'd3;
				ctrl.aluOp = ALU_MOV;
				ctrl.wrDataSel = WR_ALU;
			end
			KIND_ADDS_IMM, KIND_ADDS_REG, KIND_SUBS_IMM, KIND_SUBS_REG: begin
				ctrl.regWrite = 1'b1;
				ctrl.flagUpdate = 4'b1111;
				ctrl.reg1Loc = 2'd1;
				ctrl.wrDataSel = WR_ALU;
				if (kind == KIND_SUBS_IMM || kind == KIND_SUBS_REG) begin
					ctrl.aluOp = ALU_SUB;
				end
				// Register forms keep opBSel REG and reg2Loc 0
				if (kind == KIND_ADDS_IMM || kind == KIND_SUBS_IMM) begin
					ctrl.opBSel = OPB_IMM3;
				end
			end
			KIND_ADD_SP, KIND_SUB_SP: begin
				ctrl.regWrite = 1'b1;
				ctrl.reg3Loc = 2'd1;
				ctrl.opBSel = OPB_SPIMM;
				ctrl.aluOp = (kind == KIND_SUB_SP) ? ALU_SUB : ALU_ADD;
				ctrl.wrDataSel = WR_ALU;
			end
			KIND_CMP: begin
				ctrl.flagUpdate = 4'b1111;
				ctrl.reg1Loc = 2'd2;
				ctrl.reg2Loc = 2'd1;
				ctrl.aluOp = ALU_SUB;
			end
			KIND_ANDS, KIND_EORS, KIND_ORRS, KIND_MVNS: begin
				ctrl.regWrite = 1'b1;
				ctrl.flagUpdate = 4'b1100;
				ctrl.reg1Loc = 2'd1;
				ctrl.reg2Loc = 2'd2;
				ctrl.wrDataSel = WR_ALU;
				case (kind)
					KIND_EORS: ctrl.aluOp = ALU_EOR;
					KIND_ORRS: ctrl.aluOp = ALU_ORR;
					KIND_MVNS: ctrl.aluOp = ALU_MVN;
					default: ctrl.aluOp = ALU_AND;
				endcase
			end
			KIND_LSLS, KIND_LSRS, KIND_ASRS, KIND_RORS: begin
				ctrl.regWrite = 1'b1;
				ctrl.flagUpdate = 4'b1100;
				ctrl.reg1Loc = 2'd1;
				ctrl.reg2Loc = 2'd2;
				ctrl.wrDataSel = WR_SHIFT;
				case (kind)
					KIND_LSRS: ctrl.shiftDir = SHIFT_LSR;
					KIND_ASRS: ctrl.shiftDir = SHIFT_ASR;
					KIND_RORS: ctrl.shiftDir = SHIFT_ROR;
					default: ctrl.shiftDir = SHIFT_LSL;
				endcase
			end
			KIND_STR, KIND_LDR: begin
				// Address is base plus offset for both
				ctrl.flagUpdate = 4'b1100;
				ctrl.reg1Loc = 2'd1;
				ctrl.opBSel = OPB_OFFSET;
				ctrl.aluOp = ALU_ADD;
				if (kind == KIND_STR) begin
					ctrl.memWrite = 1'b1;
					ctrl.reg2Loc = 2'd2;
				end else begin
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.wrDataSel = WR_MEM;
				end
			end
			KIND_BCOND: begin
				ctrl.branch = 1'b1;
				ctrl.pcSel = taken ? PC_COND : PC_NEXT;
			end
			KIND_B: begin
				ctrl.branch = 1'b1;
				ctrl.pcSel = PC_UNCOND;
			end
			KIND_BL: begin
				// Link register gets the return address
				ctrl.branch = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.reg3Loc = 2'd3;
				ctrl.pcSel = PC_LINK;
				ctrl.wrDataSel = WR_IMM;
			end
			KIND_BX: begin
				ctrl.branch = 1'b1;
				ctrl.branchExchange = 1'b1;
				ctrl.reg2Loc = 2'd3;
			end
			KIND_NOP: begin
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

// File: design/cpuControl.sv
// Top level of the instruction decoder with plain datapath control ports
`timescale 1ns/10ps

module cpuControl (
	input cpuControlPkg::instrT instr,
	input cpuControlPkg::flagsT flags,

	// Write strobes
	output logic regWrite,
	output logic memWrite,
	output logic memRead,

	// Operand and result routing
	output cpuControlPkg::shiftDirE shiftDir,
	output cpuControlPkg::flagUpdateT flagUpdate,
	output cpuControlPkg::regLocT reg1Loc,
	output cpuControlPkg::regLocT reg2Loc,
	output cpuControlPkg::regLocT reg3Loc,
	output cpuControlPkg::opBSelE opBSel,
	output cpuControlPkg::aluOpE aluOp,

	// PC control
	output cpuControlPkg::pcSelE pcSel,
	output logic branch,
	output logic branchExchange,
	output cpuControlPkg::wrDataSelE wrDataSel,
	output logic illegal
);
	import cpuControlPkg::*;

	instrKindE kind;

	ctrlIf ctrlBus ();

	opcodeClassifier opcodeClassifier_i (
		.instr(instr),
		.kind(kind)
	);

	controlTable controlTable_i (
		.kind(kind),
		.instr(instr),
		.flags(flags),
		.ctrl(ctrlBus.driver)
	);

	// Bundle out to the datapath
	assign regWrite = ctrlBus.regWrite;
	assign memWrite = ctrlBus.memWrite;
	assign memRead = ctrlBus.memRead;
	assign shiftDir = ctrlBus.shiftDir;
	assign flagUpdate = ctrlBus.flagUpdate;
	assign reg1Loc = ctrlBus.reg1Loc;
	assign reg2Loc = ctrlBus.reg2Loc;
	assign reg3Loc = ctrlBus.reg3Loc;
	assign opBSel = ctrlBus.opBSel;
	assign aluOp = ctrlBus.aluOp;
	assign pcSel = ctrlBus.pcSel;
	assign branch = ctrlBus.branch;
	assign branchExchange = ctrlBus.branchExchange;
	assign wrDataSel = ctrlBus.wrDataSel;
	assign illegal = ctrlBus.illegal;

endmodule

// File: design/cpuControlPkg.sv
// Instruction, flag and control field types with the opcode match patterns of the decoder
package cpuControlPkg;

	// Instruction word and condition flags
	typedef logic [15:0] instrT;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	// Position of the condition code inside a conditional branch
	localparam int COND_MSB = 11;
	localparam int COND_LSB = 8;

	typedef enum logic [3:0] {
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL
	} condE;

	// One kind per supported instruction
	typedef enum logic [4:0] {
		KIND_MOVS, KIND_MOV,
		KIND_ADDS_IMM, KIND_ADDS_REG, KIND_SUBS_IMM, KIND_SUBS_REG,
		KIND_ADD_SP, KIND_SUB_SP,
		KIND_CMP,
		KIND_ANDS, KIND_EORS, KIND_ORRS, KIND_MVNS,
		KIND_LSLS, KIND_LSRS, KIND_ASRS, KIND_RORS,
		KIND_STR, KIND_LDR,
		KIND_BCOND, KIND_B, KIND_BL, KIND_BX, KIND_NOP,
		KIND_ILLEGAL
	} instrKindE;

	// Datapath control fields
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_ORR = 3'd3,
		ALU_EOR = 3'd4,
		ALU_MVN = 3'd5,
		ALU_MOV = 3'd6
	} aluOpE;

	typedef enum logic [1:0] {
		SHIFT_LSL = 2'd0,
		SHIFT_LSR = 2'd1,
		SHIFT_ASR = 2'd2,
		SHIFT_ROR = 2'd3
	} shiftDirE;

	typedef enum logic [1:0] {
		PC_LINK = 2'd0,
		PC_COND = 2'd1,
		PC_UNCOND = 2'd2,
		PC_NEXT = 2'd3
	} pcSelE;

	typedef enum logic [1:0] {
		WR_SHIFT = 2'd0,
		WR_ALU = 2'd1,
		WR_IMM = 2'd2,
		WR_MEM = 2'd3
	} wrDataSelE;

	typedef enum logic [2:0] {
		OPB_REG = 3'd0,
		OPB_IMM3 = 3'd1,
		OPB_SPIMM = 3'd2,
		OPB_OFFSET = 3'd3
	} opBSelE;

	typedef logic [1:0] regLocT;
	// Written flags, ordered NZCV
	typedef logic [3:0] flagUpdateT;

	// Match patterns, don't-care bits marked with ?
	localparam instrT OPC_MOVS = 16'b00100_???????????;
	localparam instrT OPC_MOV = 16'b010001100_???????;
	localparam instrT OPC_ADDS_IMM = 16'b0001110_?????????;
	localparam instrT OPC_ADDS_REG = 16'b0001100_?????????;
	localparam instrT OPC_SUBS_IMM = 16'b0001111_?????????;
	localparam instrT OPC_SUBS_REG = 16'b0001101_?????????;
	localparam instrT OPC_ADD_SP = 16'b101100000_???????;
	localparam instrT OPC_SUB_SP = 16'b101100001_???????;
	localparam instrT OPC_CMP = 16'b0100001010_??????;
	localparam instrT OPC_ANDS = 16'b0100000000_??????;
	localparam instrT OPC_EORS = 16'b0100000001_??????;
	localparam instrT OPC_ORRS = 16'b0100001100_??????;
	localparam instrT OPC_MVNS = 16'b0100001111_??????;
	localparam instrT OPC_LSLS = 16'b0100000010_??????;
	localparam instrT OPC_LSRS = 16'b0100000011_??????;
	localparam instrT OPC_ASRS = 16'b0100000100_??????;
	localparam instrT OPC_RORS = 16'b0100000111_??????;
	localparam instrT OPC_STR = 16'b01100_???????????;
	localparam instrT OPC_LDR = 16'b01101_???????????;
	localparam instrT OPC_BCOND = 16'b1101_????????????;
	localparam instrT OPC_B = 16'b11100_???????????;
	localparam instrT OPC_BL = 16'b0100010100_??????;
	localparam instrT OPC_BX = 16'b010001110_???????;
	localparam instrT OPC_NOP = 16'b1011111100_??????;

endpackage

// File: design/ctrlIf.sv
// Control bundle interface between the decode table and the top level
`timescale 1ns/10ps

interface ctrlIf;
	import cpuControlPkg::*;

	// Write strobes
	logic regWrite;
	logic memWrite;
	logic memRead;

	// Operand and result routing
	shiftDirE shiftDir;
	flagUpdateT flagUpdate;
	regLocT reg1Loc;
	regLocT reg2Loc;
	regLocT reg3Loc;
	opBSelE opBSel;
	aluOpE aluOp;
	wrDataSelE wrDataSel;

	// Program counter control
	pcSelE pcSel;
	logic branch;
	logic branchExchange;

	logic illegal;

	modport driver (
		output regWrite, memWrite, memRead, shiftDir, flagUpdate,
		output reg1Loc, reg2Loc, reg3Loc, opBSel, aluOp,
		output pcSel, branch, branchExchange, wrDataSel, illegal
	);

	modport user (
		input regWrite, memWrite, memRead, shiftDir, flagUpdate,
		input reg1Loc, reg2Loc, reg3Loc, opBSel, aluOp,
		input pcSel, branch, branchExchange, wrDataSel, illegal
	);

endinterface

// File: design/opcodeClassifier.sv
// Opcode classifier turning an instruction word into its instruction kind
`timescale 1ns/10ps

module opcodeClassifier (
	input cpuControlPkg::instrT instr,
	output cpuControlPkg::instrKindE kind
);
	import cpuControlPkg::*;

	// Condition 15 under the branch prefix is not a valid branch
	logic condReserved;

	assign condReserved = &instr[COND_MSB:COND_LSB];

	// Patterns are disjoint, so the order below carries no priority
	always_comb begin
		unique casez (instr)
			// Moves
			OPC_MOVS: kind = KIND_MOVS;
			OPC_MOV: kind = KIND_MOV;

			// Add and subtract
			OPC_ADDS_IMM: kind = KIND_ADDS_IMM;
			OPC_ADDS_REG: kind = KIND_ADDS_REG;
			OPC_SUBS_IMM: kind = KIND_SUBS_IMM;
			OPC_SUBS_REG: kind = KIND_SUBS_REG;
			OPC_ADD_SP: kind = KIND_ADD_SP;
			OPC_SUB_SP: kind = KIND_SUB_SP;
			OPC_CMP: kind = KIND_CMP;

			// Logical
			OPC_ANDS: kind = KIND_ANDS;
			OPC_EORS: kind = KIND_EORS;
			OPC_ORRS: kind = KIND_ORRS;
			OPC_MVNS: kind = KIND_MVNS;

			// Shifts
			OPC_LSLS: kind = KIND_LSLS;
			OPC_LSRS: kind = KIND_LSRS;
			OPC_ASRS: kind = KIND_ASRS;
			OPC_RORS: kind = KIND_RORS;

			// Memory
			OPC_STR: kind = KIND_STR;
			OPC_LDR: kind = KIND_LDR;

			// Control flow
			OPC_BCOND: begin
				if (condReserved) begin
					kind = KIND_ILLEGAL;
				end else begin
					kind = KIND_BCOND;
				end
			end
			OPC_B: kind = KIND_B;
			OPC_BL: kind = KIND_BL;
			OPC_BX: kind = KIND_BX;
			OPC_NOP: kind = KIND_NOP;

			default: kind = KIND_ILLEGAL;
		endcase
	end

endmodule

// File: filelist.f
design/cpuControlPkg.sv
design/ctrlIf.sv
design/opcodeClassifier.sv
design/branchCondition.sv
design/controlTable.sv
design/cpuControl.sv
tb/controlChecker.sv
tb/cpuControlTb.sv

// File: tb/controlChecker.sv
// Reference decode model, output comparison and error counting for the decoder
`timescale 1ns/10ps

module controlChecker (
	input logic clk,
	input logic arstN,
	input logic checkEn,
	input logic done,
	input logic [2:0] testId,
	input cpuControlPkg::instrT instr,
	input cpuControlPkg::flagsT flags,
	input logic regWrite,
	input logic memWrite,
	input logic memRead,
	input logic [1:0] shiftDir,
	input logic [3:0] flagUpdate,
	input logic [1:0] reg1Loc,
	input logic [1:0] reg2Loc,
	input logic [1:0] reg3Loc,
	input logic [2:0] opBSel,
	input logic [2:0] aluOp,
	input logic [1:0] pcSel,
	input logic branch,
	input logic branchExchange,
	input logic [1:0] wrDataSel,
	input logic illegal,
	output int errorCount
);
	import cpuControlPkg::*;

	localparam int IDX_PC_SEL = 10;
	localparam int IDX_BRANCH = 11;
	localparam int IDX_BX = 12;
	localparam int IDX_ILLEGAL = 14;

	// Expected bundle in port order, -1 for fields the kind leaves unused
	int expected [15];
	int checks = 0;
	int valueErrors = 0;
	int unknownErrors = 0;

	assign errorCount = valueErrors + unknownErrors;

	function automatic string testName(input logic [2:0] id);
		case (id)
			3'd1: return "dataProcessing";
			3'd2: return "memory";
			3'd3: return "condBranch";
			3'd4: return "uncondControl";
			3'd5: return "illegalWords";
			default: return "none";
		endcase
	endfunction

	// Opcode rules, longest prefixes first
	function automatic instrKindE classify(input instrT w);
		case (w[15:6])
			10'b0100001010: return KIND_CMP;
			10'b0100000000: return KIND_ANDS;
			10'b0100000001: return KIND_EORS;
			10'b0100001100: return KIND_ORRS;
			10'b0100001111: return KIND_MVNS;
			10'b0100000010: return KIND_LSLS;
			10'b0100000011: return KIND_LSRS;
			10'b0100000100: return KIND_ASRS;
			10'b0100000111: return KIND_RORS;
			10'b0100010100: return KIND_BL;
			10'b1011111100: return KIND_NOP;
			default: ;
		endcase
		case (w[15:7])
			9'b010001100: return KIND_MOV;
			9'b101100000: return KIND_ADD_SP;
			9'b101100001: return KIND_SUB_SP;
			9'b010001110: return KIND_BX;
			default: ;
		endcase
		case (w[15:9])
			7'b0001110: return KIND_ADDS_IMM;
			7'b0001100: return KIND_ADDS_REG;
			7'b0001111: return KIND_SUBS_IMM;
			7'b0001101: return KIND_SUBS_REG;
			default: ;
		endcase
		case (w[15:11])
			5'b00100: return KIND_MOVS;
			5'b01100: return KIND_STR;
			5'b01101: return KIND_LDR;
			5'b11100: return KIND_B;
			default: ;
		endcase
		if (w[15:12] == 4'b1101 && w[COND_MSB:COND_LSB] != 4'hF) begin
			return KIND_BCOND;
		end
		return KIND_ILLEGAL;
	endfunction

	// Even codes test the base term, odd codes its inverse
	function automatic logic condHolds(input logic [3:0] cond, input flagsT f);
		logic base;
		case (cond[3:1])
			3'd0: base = f.z;
			3'd1: base = f.c;
			3'd2: base = f.n;
			3'd3: base = f.v;
			3'd4: base = f.c & ~f.z;
			3'd5: base = (f.n == f.v);
			3'd6: base = ~f.z & (f.n == f.v);
			default: base = 1'b1;
		endcase
		return base ^ cond[0];
	endfunction

	task automatic row(input int regW, input int memW, input int memR, input int shift,
		input int mask, input int r1, input int r2, input int r3, input int opB,
		input int alu, input int wr);
		expected[0] = regW;
		expected[1] = memW;
		expected[2] = memR;
		expected[3] = shift;
		expected[4] = mask;
		expected[5] = r1;
		expected[6] = r2;
		expected[7] = r3;
		expected[8] = opB;
		expected[9] = alu;
		expected[13] = wr;
	endtask

	task automatic buildExpected(input instrKindE kind, input instrT w, input flagsT f);
		row(0, 0, 0, -1, 4'b0000, -1, -1, -1, -1, -1, -1);
		expected[IDX_PC_SEL] = PC_NEXT;
		expected[IDX_BRANCH] = 0;
		expected[IDX_BX] = 0;
		expected[IDX_ILLEGAL] = 0;
		case (kind)
			KIND_MOVS: row(1, 0, 0, -1, 4'b1100, -1, -1, 2, -1, -1, WR_IMM);
			KIND_MOV: row(1, 0, 0, -1, 4'b0000, -1, 3, 0, OPB_REG, ALU_MOV, WR_ALU);
			KIND_ADDS_IMM: row(1, 0, 0, -1, 4'b1111, 1, -1, 0, OPB_IMM3, ALU_ADD, WR_ALU);
			KIND_ADDS_REG: row(1, 0, 0, -1, 4'b1111, 1, 0, 0, OPB_REG, ALU_ADD, WR_ALU);
			KIND_SUBS_IMM: row(1, 0, 0, -1, 4'b1111, 1, -1, 0, OPB_IMM3, ALU_SUB, WR_ALU);
			KIND_SUBS_REG: row(1, 0, 0, -1, 4'b1111, 1, 0, 0, OPB_REG, ALU_SUB, WR_ALU);
			KIND_ADD_SP: row(1, 0, 0, -1, 4'b0000, -1, -1, 1, OPB_SPIMM, ALU_ADD, WR_ALU);
			KIND_SUB_SP: row(1, 0, 0, -1, 4'b0000, -1, -1, 1, OPB_SPIMM, ALU_SUB, WR_ALU);
			KIND_CMP: row(0, 0, 0, -1, 4'b1111, 2, 1, -1, OPB_REG, ALU_SUB, -1);
			KIND_ANDS: row(1, 0, 0, -1, 4'b1100, 1, 2, 0, OPB_REG, ALU_AND, WR_ALU);
			KIND_EORS: row(1, 0, 0, -1, 4'b1100, 1, 2, 0, OPB_REG, ALU_EOR, WR_ALU);
			KIND_ORRS: row(1, 0, 0, -1, 4'b1100, 1, 2, 0, OPB_REG, ALU_ORR, WR_ALU);
			KIND_MVNS: row(1, 0, 0, -1, 4'b1100, 1, 2, 0, OPB_REG, ALU_MVN, WR_ALU);
			KIND_LSLS: row(1, 0, 0, SHIFT_LSL, 4'b1100, 1, 2, 0, -1, -1, WR_SHIFT);
			KIND_LSRS: row(1, 0, 0, SHIFT_LSR, 4'b1100, 1, 2, 0, -1, -1, WR_SHIFT);
			KIND_ASRS: row(1, 0, 0, SHIFT_ASR, 4'b1100, 1, 2, 0, -1, -1, WR_SHIFT);
			KIND_RORS: row(1, 0, 0, SHIFT_ROR, 4'b1100, 1, 2, 0, -1, -1, WR_SHIFT);
			KIND_STR: row(0, 1, 0, -1, 4'b1100, 1, 2, 0, OPB_OFFSET, ALU_ADD, -1);
			KIND_LDR: row(1, 0, 1, -1, 4'b1100, 1, -1, 0, OPB_OFFSET, ALU_ADD, WR_MEM);
			KIND_BCOND: begin
				expected[IDX_BRANCH] = 1;
				expected[IDX_PC_SEL] = condHolds(w[COND_MSB:COND_LSB], f) ? PC_COND : PC_NEXT;
			end
			KIND_B: begin
				expected[IDX_BRANCH] = 1;
				expected[IDX_PC_SEL] = PC_UNCOND;
			end
			KIND_BL: begin
				// Return address goes to the link register
				row(1, 0, 0, -1, 4'b0000, -1, -1, 3, -1, -1, WR_IMM);
				expected[IDX_BRANCH] = 1;
				expected[IDX_PC_SEL] = PC_LINK;
			end
			KIND_BX: begin
				row(0, 0, 0, -1, 4'b0000, -1, 3, -1, -1, -1, -1);
				expected[IDX_BRANCH] = 1;
				expected[IDX_BX] = 1;
			end
			KIND_NOP: ;
			default: expected[IDX_ILLEGAL] = 1;
		endcase
	endtask

	task automatic checkField(input string field, input int expVal, input int actVal);
		if (expVal >= 0 && expVal != actVal) begin
			valueErrors++;
			$display("[ERROR] %s %s expected %0d actual %0d (instr %h flags %b)",
				testName(testId), field, expVal, actVal, instr, flags);
		end
	endtask

	// Inputs change on the rising edge, outputs are sampled on the falling edge
	always @(negedge clk or negedge arstN) begin
		if (!arstN) begin
			checks = 0;
			valueErrors = 0;
			unknownErrors = 0;
		end else if (checkEn) begin
			checks++;
			if ($isunknown({regWrite, memWrite, memRead, shiftDir, flagUpdate, reg1Loc,
				reg2Loc, reg3Loc, opBSel, aluOp, pcSel, branch, branchExchange,
				wrDataSel, illegal})) begin
				unknownErrors++;
				$display("Decoder output is unknown in test %s for instr %h",
					testName(testId), instr);
			end else begin
				buildExpected(classify(instr), instr, flags);
				checkField("regWrite", expected[0], regWrite);
				checkField("memWrite", expected[1], memWrite);
				checkField("memRead", expected[2], memRead);
				checkField("shiftDir", expected[3], shiftDir);
				checkField("flagUpdate", expected[4], flagUpdate);
				checkField("reg1Loc", expected[5], reg1Loc);
				checkField("reg2Loc", expected[6], reg2Loc);
				checkField("reg3Loc", expected[7], reg3Loc);
				checkField("opBSel", expected[8], opBSel);
				checkField("aluOp", expected[9], aluOp);
				checkField("pcSel", expected[IDX_PC_SEL], pcSel);
				checkField("branch", expected[IDX_BRANCH], branch);
				checkField("branchExchange", expected[IDX_BX], branchExchange);
				checkField("wrDataSel", expected[13], wrDataSel);
				checkField("illegal", expected[IDX_ILLEGAL], illegal);
			end
		end
	end

	always @(posedge done) begin
		$display("Checked %0d words, value errors %0d, unknown output errors %0d",
			checks, valueErrors, unknownErrors);
	end

endmodule

// File: tb/cpuControlTb.sv
// Testbench top with clock, reset, LFSR stimulus, watchdog and the decoder instance
`timescale 1ns/10ps

module cpuControlTb;
	import cpuControlPkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int DP_TESTS = 300;
	localparam int MEM_TESTS = 100;
	localparam int BCOND_TESTS = 400;
	localparam int UNCOND_TESTS = 100;
	localparam int RANDOM_TESTS = 300;
	localparam int TOTAL_TESTS = DP_TESTS + MEM_TESTS + BCOND_TESTS + UNCOND_TESTS
		+ RANDOM_TESTS;
	// One cycle per test plus reset and a margin
	localparam int WATCHDOG_NS = (TOTAL_TESTS + RESET_CYCLES + 100) * CLK_PERIOD;

	logic clk;
	logic arstN;
	logic checkEn;
	logic done;
	logic [2:0] testId;
	logic [31:0] lfsrState;
	int errorCount;

	instrT instr;
	flagsT flags;
	logic regWrite, memWrite, memRead, branch, branchExchange, illegal;
	shiftDirE shiftDir;
	flagUpdateT flagUpdate;
	regLocT reg1Loc, reg2Loc, reg3Loc;
	opBSelE opBSel;
	aluOpE aluOp;
	pcSelE pcSel;
	wrDataSelE wrDataSel;

	cpuControl cpuControl_i (
		.instr(instr), .flags(flags),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.shiftDir(shiftDir), .flagUpdate(flagUpdate),
		.reg1Loc(reg1Loc), .reg2Loc(reg2Loc), .reg3Loc(reg3Loc),
		.opBSel(opBSel), .aluOp(aluOp), .pcSel(pcSel),
		.branch(branch), .branchExchange(branchExchange),
		.wrDataSel(wrDataSel), .illegal(illegal)
	);

	controlChecker controlChecker_i (
		.clk(clk), .arstN(arstN), .checkEn(checkEn), .done(done), .testId(testId),
		.instr(instr), .flags(flags),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.shiftDir(shiftDir), .flagUpdate(flagUpdate),
		.reg1Loc(reg1Loc), .reg2Loc(reg2Loc), .reg3Loc(reg3Loc),
		.opBSel(opBSel), .aluOp(aluOp), .pcSel(pcSel),
		.branch(branch), .branchExchange(branchExchange),
		.wrDataSel(wrDataSel), .illegal(illegal),
		.errorCount(errorCount)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic takeBits(input int count, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[14:0], lfsrState[0]};
		end
	endtask

	// Fixed top bits, random low bits and random flags
	task automatic applyWord(input logic [2:0] id, input logic [15:0] prefix, input int width);
		logic [15:0] fill;
		logic [15:0] flagBits;
		takeBits(16 - width, fill);
		takeBits(4, flagBits);
		@(posedge clk);
		instr <= (prefix << (16 - width)) | fill;
		flags <= flagsT'(flagBits[3:0]);
		testId <= id;
		checkEn <= 1'b1;
	endtask

	task automatic dataProcWord();
		logic [15:0] pick;
		takeBits(4, pick);
		case (pick[3:0])
			4'd0: applyWord(1, 16'b010001100, 9);
			4'd1: applyWord(1, 16'b0001110, 7);
			4'd2: applyWord(1, 16'b0001100, 7);
			4'd3: applyWord(1, 16'b0001111, 7);
			4'd4: applyWord(1, 16'b0001101, 7);
			4'd5: applyWord(1, 16'b101100000, 9);
			4'd6: applyWord(1, 16'b101100001, 9);
			4'd7: applyWord(1, 16'b0100001010, 10);
			4'd8: applyWord(1, 16'b0100000000, 10);
			4'd9: applyWord(1, 16'b0100000001, 10);
			4'd10: applyWord(1, 16'b0100001100, 10);
			4'd11: applyWord(1, 16'b0100001111, 10);
			4'd12: applyWord(1, 16'b0100000010, 10);
			4'd13: applyWord(1, 16'b0100000011, 10);
			4'd14: applyWord(1, 16'b0100000100, 10);
			default: applyWord(1, 16'b0100000111, 10);
		endcase
	endtask

	// B, BL, BX or NOP
	task automatic uncondWord();
		logic [15:0] pick;
		takeBits(2, pick);
		case (pick[1:0])
			2'd0: applyWord(4, 16'b11100, 5);
			2'd1: applyWord(4, 16'b0100010100, 10);
			2'd2: applyWord(4, 16'b010001110, 9);
			default: applyWord(4, 16'b1011111100, 10);
		endcase
	endtask

	initial begin : stimulus
		logic [15:0] bits;
		lfsrState = 32'h3267;
		instr = '0;
		flags = '0;
		checkEn = 1'b0;
		done = 1'b0;
		testId = '0;
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arstN <= 1'b1;

		repeat (DP_TESTS) dataProcWord();
		repeat (MEM_TESTS) applyWord(2, 16'b0110, 4);
		repeat (BCOND_TESTS) begin
			// Redraw until the condition is 0 to 14
			bits = 16'hF;
			while (bits[3:0] == 4'hF) begin
				takeBits(4, bits);
			end
			applyWord(3, {12'b1101, bits[3:0]}, 8);
		end
		repeat (UNCOND_TESTS) uncondWord();
		for (int n = 0; n < RANDOM_TESTS; n++) begin
			// Every sixth word uses the reserved condition 15
			if (n % 6 == 0) begin
				applyWord(5, 16'b11011111, 8);
			end else begin
				takeBits(16, bits);
				applyWord(5, bits, 16);
			end
		end

		@(posedge clk);
		checkEn <= 1'b0;
		done <= 1'b1;
		@(negedge clk);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the stimulus never finished", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule
